/* mipsPkg.sv */
package mipsPkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int NB_DATA  = 32;
    localparam int NB_ADDR  = 5;   // register index
    localparam int NB_SHAMT = 5;
    localparam int NB_IMM   = 16;

    localparam logic [NB_DATA-1:0] NOP_WORD = '0;  // sll r0, r0, 0

    // ----------------------------------------
    // instruction encodings
    // ----------------------------------------
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funcE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOpE;

    // operand source chosen by the forwarding unit
    typedef enum logic [1:0] {
        FW_REG   = 2'd0,
        FW_EXMEM = 2'd1,
        FW_MEMWB = 2'd2
    } fwSelE;

endpackage

/* stageIf.sv */
// ID/EX bundle, written by decode and read by execute
interface idExIf;
    import mipsPkg::*;

    logic [NB_ADDR-1:0]  rs;
    logic [NB_ADDR-1:0]  rt;
    logic [NB_ADDR-1:0]  rd;
    logic [NB_SHAMT-1:0] shamt;
    logic [NB_DATA-1:0]  regA;
    logic [NB_DATA-1:0]  regB;
    logic [NB_DATA-1:0]  immediate;   // already extended
    aluOpE               aluOp;
    logic                aluSrcImm;
    logic                regDst;      // 1 selects rd
    logic                memRead;
    logic                memWrite;
    logic                regWrite;

    modport decode (output rs, rt, rd, shamt, regA, regB, immediate,
                    aluOp, aluSrcImm, regDst, memRead, memWrite, regWrite);
    modport execute (input rs, rt, rd, shamt, regA, regB, immediate,
                     aluOp, aluSrcImm, regDst, memRead, memWrite, regWrite);
endinterface

// EX/MEM bundle, written by execute
interface exMemIf;
    import mipsPkg::*;

    logic [NB_DATA-1:0] aluResult;   // also the data address
    logic [NB_DATA-1:0] storeData;
    logic [NB_ADDR-1:0] writeReg;
    logic               memRead;
    logic               memWrite;
    logic               regWrite;

    modport execute (output aluResult, storeData, writeReg,
                     memRead, memWrite, regWrite);
    modport memory (input aluResult, storeData, writeReg,
                    memRead, memWrite, regWrite);
    modport forward (input writeReg, regWrite);
endinterface

/* instructionFetch.sv */
module instructionFetch #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_we,
    input  logic [mipsPkg::NB_DATA-1:0]  i_instructionData,
    input  logic                         i_halt,
    input  logic                         i_jump,
    input  logic [mipsPkg::NB_DATA-1:0]  i_jumpTarget,
    output logic [mipsPkg::NB_DATA-1:0]  o_instruction,
    output logic [mipsPkg::NB_DATA-1:0]  o_pcPlus4
);
    import mipsPkg::*;

    localparam int NB_IADDR = $clog2(IMEM_DEPTH);

    logic [NB_DATA-1:0]  instrMem [IMEM_DEPTH];
    logic [NB_IADDR-1:0] loadPtr;
    logic [NB_DATA-1:0]  pc;
    logic [NB_DATA-1:0]  pcNext;
    logic [NB_DATA-1:0]  fetched;
    logic                jumpPending;      // jump decoded while halted
    logic [NB_DATA-1:0]  jumpPendingTarget;

    // program load port, one word per cycle
    always_ff @(posedge clk) begin
        if (i_we) begin
            instrMem[loadPtr] <= i_instructionData;
        end
    end

    assign fetched = instrMem[pc[NB_IADDR+1:2]];  // word address

    always_comb begin
        if (i_jump) begin
            pcNext = i_jumpTarget;
        end else if (jumpPending) begin
            pcNext = jumpPendingTarget;
        end else begin
            pcNext = pc + NB_DATA'(4);
        end
    end

    // ----------------------------------------
    // pc and IF/ID register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc            <= '0;
            loadPtr       <= '0;
            jumpPending   <= 1'b0;
            o_instruction <= NOP_WORD;
            o_pcPlus4     <= '0;
        end else if (i_we) begin
            loadPtr       <= loadPtr + 1'b1;
            pc            <= '0;              // start at 0 once loading ends
            o_instruction <= NOP_WORD;
        end else if (i_halt) begin
            o_instruction <= NOP_WORD;        // bubbles while pc holds
            if (i_jump) begin
                jumpPending       <= 1'b1;
                jumpPendingTarget <= i_jumpTarget;
            end
        end else begin
            pc            <= pcNext;
            jumpPending   <= 1'b0;
            o_instruction <= fetched;
            o_pcPlus4     <= pc + NB_DATA'(4);
        end
    end

endmodule

/* instructionDecode.sv */
module instructionDecode (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic [mipsPkg::NB_DATA-1:0]  i_instruction,
    input  logic [mipsPkg::NB_DATA-1:0]  i_pcPlus4,
    input  logic                         i_writeEnable,
    input  logic [mipsPkg::NB_ADDR-1:0]  i_writeReg,
    input  logic [mipsPkg::NB_DATA-1:0]  i_writeData,
    output logic                         o_jump,
    output logic [mipsPkg::NB_DATA-1:0]  o_jumpTarget,
    idExIf.decode                        idEx
);
    import mipsPkg::*;

    localparam int NUM_REGS = 2 ** NB_ADDR;

    opcodeE              opcode;
    funcE                func;
    logic [NB_ADDR-1:0]  rs;
    logic [NB_ADDR-1:0]  rt;
    logic [NB_ADDR-1:0]  rd;
    logic [NB_IMM-1:0]   imm16;
    logic [NB_DATA-1:0]  immediate;
    logic [NB_DATA-1:0]  regA;
    logic [NB_DATA-1:0]  regB;
    logic [NB_DATA-1:0]  regFile [NUM_REGS];

    aluOpE aluOp;
    logic  aluSrcImm, regDst, memRead, memWrite, regWrite, signExt;

    assign opcode = opcodeE'(i_instruction[31:26]);
    assign func   = funcE'(i_instruction[5:0]);
    assign rs     = i_instruction[25:21];
    assign rt     = i_instruction[20:16];
    assign rd     = i_instruction[15:11];
    assign imm16  = i_instruction[NB_IMM-1:0];

    // ----------------------------------------
    // control decode
    // ----------------------------------------
    always_comb begin
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        regDst    = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        signExt   = 1'b1;
        o_jump    = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                regDst   = 1'b1;
                regWrite = (i_instruction != NOP_WORD);  // bubbles stay silent
                case (func)
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    default: regWrite = 1'b0;
                endcase
            end
            OP_J:     o_jump = 1'b1;
            OP_ADDIU: begin aluSrcImm = 1'b1; regWrite = 1'b1; end
            OP_ANDI:  begin aluOp = ALU_AND; aluSrcImm = 1'b1; regWrite = 1'b1; signExt = 1'b0; end
            OP_ORI:   begin aluOp = ALU_OR; aluSrcImm = 1'b1; regWrite = 1'b1; signExt = 1'b0; end
            OP_LUI:   begin aluOp = ALU_LUI; aluSrcImm = 1'b1; regWrite = 1'b1; end
            OP_LW:    begin aluSrcImm = 1'b1; memRead = 1'b1; regWrite = 1'b1; end
            OP_SW:    begin aluSrcImm = 1'b1; memWrite = 1'b1; end
            default:  ;
        endcase
    end

    assign immediate = signExt ? {{(NB_DATA-NB_IMM){imm16[NB_IMM-1]}}, imm16}
                               : {{(NB_DATA-NB_IMM){1'b0}}, imm16};

    assign o_jumpTarget = {i_pcPlus4[31:28], i_instruction[25:0], 2'b00};

    // ----------------------------------------
    // register file, r0 always reads zero
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_writeEnable && i_writeReg != '0) begin
            regFile[i_writeReg] <= i_writeData;
        end
    end

    // write-first bypass from write-back
    assign regA = (rs == '0) ? '0 :
                  (i_writeEnable && i_writeReg == rs) ? i_writeData : regFile[rs];
    assign regB = (rt == '0) ? '0 :
                  (i_writeEnable && i_writeReg == rt) ? i_writeData : regFile[rt];

    // ID/EX register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            idEx.aluOp     <= ALU_ADD;
            idEx.aluSrcImm <= 1'b0;
            idEx.regDst    <= 1'b0;
            idEx.memRead   <= 1'b0;
            idEx.memWrite  <= 1'b0;
            idEx.regWrite  <= 1'b0;
        end else begin
            idEx.aluOp     <= aluOp;
            idEx.aluSrcImm <= aluSrcImm;
            idEx.regDst    <= regDst;
            idEx.memRead   <= memRead;
            idEx.memWrite  <= memWrite;
            idEx.regWrite  <= regWrite;
        end
    end

    always_ff @(posedge clk) begin
        idEx.rs        <= rs;
        idEx.rt        <= rt;
        idEx.rd        <= rd;
        idEx.shamt     <= i_instruction[10:6];
        idEx.regA      <= regA;
        idEx.regB      <= regB;
        idEx.immediate <= immediate;
    end

endmodule

/* forwardingUnit.sv */
module forwardingUnit (
    input  logic [mipsPkg::NB_ADDR-1:0]  i_rs,
    input  logic [mipsPkg::NB_ADDR-1:0]  i_rt,
    exMemIf.forward                      exMem,
    input  logic                         i_wbWriteEnable,
    input  logic [mipsPkg::NB_ADDR-1:0]  i_wbWriteReg,
    output mipsPkg::fwSelE               o_fwA,
    output mipsPkg::fwSelE               o_fwB
);
    import mipsPkg::*;

    // newest producer wins, r0 never forwards
    function automatic fwSelE fwSelect(
        input logic [NB_ADDR-1:0] src,
        input logic               exWe,
        input logic [NB_ADDR-1:0] exReg,
        input logic               wbWe,
        input logic [NB_ADDR-1:0] wbReg
    );
        if (exWe && exReg != '0 && exReg == src) begin
            return FW_EXMEM;
        end else if (wbWe && wbReg != '0 && wbReg == src) begin
            return FW_MEMWB;
        end
        return FW_REG;
    endfunction

    assign o_fwA = fwSelect(i_rs, exMem.regWrite, exMem.writeReg, i_wbWriteEnable, i_wbWriteReg);
    assign o_fwB = fwSelect(i_rt, exMem.regWrite, exMem.writeReg, i_wbWriteEnable, i_wbWriteReg);

endmodule

/* instructionExecute.sv */
module instructionExecute (
    input  logic                         clk,
    input  logic                         i_rst,
    idExIf.execute                       idEx,
    input  mipsPkg::fwSelE               i_fwA,
    input  mipsPkg::fwSelE               i_fwB,
    input  logic [mipsPkg::NB_DATA-1:0]  i_wbWriteData,
    exMemIf.execute                      exMem
);
    import mipsPkg::*;

    logic [NB_DATA-1:0] srcA;
    logic [NB_DATA-1:0] fwdB;       // forwarded rt value, also store data
    logic [NB_DATA-1:0] srcB;
    logic [NB_DATA-1:0] aluResult;
    logic [NB_ADDR-1:0] writeReg;

    // ----------------------------------------
    // operand muxes
    // ----------------------------------------
    always_comb begin
        case (i_fwA)
            FW_EXMEM: srcA = exMem.aluResult;
            FW_MEMWB: srcA = i_wbWriteData;
            default:  srcA = idEx.regA;
        endcase
        case (i_fwB)
            FW_EXMEM: fwdB = exMem.aluResult;
            FW_MEMWB: fwdB = i_wbWriteData;
            default:  fwdB = idEx.regB;
        endcase
    end

    assign srcB = idEx.aluSrcImm ? idEx.immediate : fwdB;

    // ALU
    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_XOR: aluResult = srcA ^ srcB;
            ALU_SLT: aluResult = {{(NB_DATA-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLL: aluResult = srcB << idEx.shamt;
            ALU_LUI: aluResult = srcB << 16;
            default: aluResult = '0;
        endcase
    end

    assign writeReg = idEx.regDst ? idEx.rd : idEx.rt;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.regWrite <= 1'b0;
        end else begin
            exMem.memRead  <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
            exMem.regWrite <= idEx.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMem.aluResult <= aluResult;
        exMem.storeData <= fwdB;
        exMem.writeReg  <= writeReg;
    end

endmodule

/* memoryWriteBack.sv */
module memoryWriteBack #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         i_rst,
    exMemIf.memory                       exMem,
    output logic                         o_writeEnable,
    output logic [mipsPkg::NB_ADDR-1:0]  o_writeReg,
    output logic [mipsPkg::NB_DATA-1:0]  o_writeData,
    output logic                         o_memWrite,
    output logic [mipsPkg::NB_DATA-1:0]  o_dataAddr,
    output logic [mipsPkg::NB_DATA-1:0]  o_dataToMem
);
    import mipsPkg::*;

    localparam int NB_DADDR = $clog2(DMEM_DEPTH);

    logic [NB_DATA-1:0]  dataMem [DMEM_DEPTH];
    logic [NB_DADDR-1:0] wordAddr;
    logic [NB_DATA-1:0]  wbReadData;
    logic [NB_DATA-1:0]  wbAluResult;
    logic                wbMemToReg;

    assign wordAddr = exMem.aluResult[NB_DADDR+1:2];

    // ----------------------------------------
    // data memory, read lands in MEM/WB
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (exMem.memWrite) begin
            dataMem[wordAddr] <= exMem.storeData;
        end
        wbReadData <= dataMem[wordAddr];
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_writeEnable <= 1'b0;
            wbMemToReg    <= 1'b0;
        end else begin
            o_writeEnable <= exMem.regWrite;
            wbMemToReg    <= exMem.memRead;
        end
    end

    always_ff @(posedge clk) begin
        wbAluResult <= exMem.aluResult;
        o_writeReg  <= exMem.writeReg;
    end

    assign o_writeData = wbMemToReg ? wbReadData : wbAluResult;  // write-back select

    // store strobes straight from EX/MEM
    assign o_memWrite  = exMem.memWrite;
    assign o_dataAddr  = exMem.aluResult;
    assign o_dataToMem = exMem.storeData;

endmodule

/* pipeline.sv */
module pipeline #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_we,
    input  logic [mipsPkg::NB_DATA-1:0]  i_instructionData,
    input  logic                         i_halt,
    output logic                         o_writeEnable,
    output logic [mipsPkg::NB_ADDR-1:0]  o_writeReg,
    output logic [mipsPkg::NB_DATA-1:0]  o_writeData,
    output logic                         o_memWrite,
    output logic [mipsPkg::NB_DATA-1:0]  o_dataAddr,
    output logic [mipsPkg::NB_DATA-1:0]  o_dataToMem
);
    import mipsPkg::*;

    // ----------------------------------------
    // stage links
    // ----------------------------------------
    logic [NB_DATA-1:0] instructionIfId;
    logic [NB_DATA-1:0] pcPlus4IfId;
    logic               jump;             // decode back to fetch
    logic [NB_DATA-1:0] jumpTarget;
    fwSelE              fwA;
    fwSelE              fwB;
    logic               wbWriteEnable;
    logic [NB_ADDR-1:0] wbWriteReg;
    logic [NB_DATA-1:0] wbWriteData;

    idExIf  idEx ();
    exMemIf exMem ();

    instructionFetch #(.IMEM_DEPTH(IMEM_DEPTH)) uFetch (
        .clk(clk), .i_rst(i_rst), .i_we(i_we), .i_instructionData(i_instructionData),
        .i_halt(i_halt), .i_jump(jump), .i_jumpTarget(jumpTarget),
        .o_instruction(instructionIfId), .o_pcPlus4(pcPlus4IfId)
    );

    instructionDecode uDecode (
        .clk(clk), .i_rst(i_rst), .i_instruction(instructionIfId), .i_pcPlus4(pcPlus4IfId),
        .i_writeEnable(wbWriteEnable), .i_writeReg(wbWriteReg), .i_writeData(wbWriteData),
        .o_jump(jump), .o_jumpTarget(jumpTarget), .idEx(idEx)
    );

    forwardingUnit uForward (
        .i_rs(idEx.rs), .i_rt(idEx.rt), .exMem(exMem),
        .i_wbWriteEnable(wbWriteEnable), .i_wbWriteReg(wbWriteReg),
        .o_fwA(fwA), .o_fwB(fwB)
    );

    instructionExecute uExecute (
        .clk(clk), .i_rst(i_rst), .idEx(idEx), .i_fwA(fwA), .i_fwB(fwB),
        .i_wbWriteData(wbWriteData), .exMem(exMem)
    );

    memoryWriteBack #(.DMEM_DEPTH(DMEM_DEPTH)) uMemory (
        .clk(clk), .i_rst(i_rst), .exMem(exMem),
        .o_writeEnable(wbWriteEnable), .o_writeReg(wbWriteReg), .o_writeData(wbWriteData),
        .o_memWrite(o_memWrite), .o_dataAddr(o_dataAddr), .o_dataToMem(o_dataToMem)
    );

    assign o_writeEnable = wbWriteEnable;
    assign o_writeReg    = wbWriteReg;
    assign o_writeData   = wbWriteData;

endmodule

/* tbClock.sv */
module tbClock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;   // released on a rising edge
    end

endmodule

/* tbPipeline.sv */
module tbPipeline;
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPkg::*;

    localparam int HALT_START = 10;   // cycles into execution
    localparam int HALT_LEN   = 6;
    localparam int DRAIN      = 8;    // idle cycles that must stay silent

    logic               clk;
    logic               rst;
    logic               i_we;
    logic [NB_DATA-1:0] i_instructionData;
    logic               i_halt;
    logic               o_writeEnable;
    logic [NB_ADDR-1:0] o_writeReg;
    logic [NB_DATA-1:0] o_writeData;
    logic               o_memWrite;
    logic [NB_DATA-1:0] o_dataAddr;
    logic [NB_DATA-1:0] o_dataToMem;

    // ----------------------------------------
    // program and expected event tables
    // ----------------------------------------
    logic [NB_DATA-1:0] prog [$];
    logic [NB_ADDR-1:0] expReg [$];
    logic [NB_DATA-1:0] expVal [$];
    int                 expWbCycle [$];   // cycle count when each write-back shows
    logic [NB_DATA-1:0] expAddr [$];
    logic [NB_DATA-1:0] expData [$];
    int                 expStCycle [$];
    logic [NB_DATA-1:0] model [32];   // architectural register values

    integer seed;
    int     errors;
    int     checks;
    int     wbIdx;
    int     stIdx;
    int     cycles;
    int     limit;
    int     slot;     // fetch slot of the next executed word

    tbClock #(.PERIOD(8), .RESET_CYCLES(8)) uClock (.o_clk(clk), .o_rst(rst));

    pipeline #(.IMEM_DEPTH(64), .DMEM_DEPTH(64)) UUT (
        .clk(clk), .i_rst(rst), .i_we(i_we), .i_instructionData(i_instructionData),
        .i_halt(i_halt), .o_writeEnable(o_writeEnable), .o_writeReg(o_writeReg),
        .o_writeData(o_writeData), .o_memWrite(o_memWrite), .o_dataAddr(o_dataAddr),
        .o_dataToMem(o_dataToMem)
    );

    function automatic logic [NB_DATA-1:0] rType(input funcE fn, input logic [4:0] rd,
            input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [NB_DATA-1:0] iType(input opcodeE op, input logic [4:0] rs,
            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [NB_DATA-1:0] jType(input logic [25:0] index);
        return {OP_J, index};
    endfunction

    function automatic logic [NB_DATA-1:0] sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // slots fetched from the halt on come out late by its length
    function automatic int eventCycle(input int fetchSlot, input int latency);
        return fetchSlot + latency + ((fetchSlot >= HALT_START) ? HALT_LEN : 0);
    endfunction

    task automatic appendWord(input logic [NB_DATA-1:0] word);
        prog.push_back(word);
        slot++;
    endtask

    task automatic appendSkipped(input logic [NB_DATA-1:0] word);
        prog.push_back(word);   // jumped over, never fetched
    endtask

    task automatic addWriteBack(input logic [NB_ADDR-1:0] rd, input logic [NB_DATA-1:0] val);
        expReg.push_back(rd);
        expVal.push_back(val);
        expWbCycle.push_back(eventCycle(slot - 1, 4));
        if (rd != '0) begin
            model[rd] = val;   // r0 keeps reading zero
        end
    endtask

    task automatic addStore(input logic [NB_DATA-1:0] addr, input logic [NB_DATA-1:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
        expStCycle.push_back(eventCycle(slot - 1, 3));
    endtask

    task automatic buildProgram();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        logic [15:0] immD;
        logic [15:0] immE;
        logic [4:0]  sh;
        int          rnd;
        seed = 32'he4df;
        slot = 0;
        rnd = $random(seed);
        immA = rnd[15:0];
        rnd = $random(seed);
        immB = rnd[15:0];
        rnd = $random(seed);
        immC = rnd[15:0];
        rnd = $random(seed);
        immD = rnd[15:0];
        rnd = $random(seed);
        immE = rnd[15:0];
        rnd = $random(seed);
        sh = (rnd[4:0] == 5'd0) ? 5'd7 : rnd[4:0];
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        // immediates, sign and zero extension
        appendWord(iType(OP_ADDIU, 0, 1, immA));
        addWriteBack(1, sext(immA));
        appendWord(iType(OP_ORI, 0, 2, immB));
        addWriteBack(2, {16'h0, immB});
        appendWord(iType(OP_LUI, 0, 3, immC));
        addWriteBack(3, {immC, 16'h0});
        // dependent chain through EX/MEM and MEM/WB
        appendWord(rType(FN_ADDU, 4, 1, 2, 0));
        addWriteBack(4, model[1] + model[2]);
        appendWord(rType(FN_SUBU, 5, 4, 3, 0));
        addWriteBack(5, model[4] - model[3]);
        appendWord(rType(FN_AND, 6, 5, 4, 0));
        addWriteBack(6, model[5] & model[4]);
        appendWord(rType(FN_OR, 7, 6, 1, 0));
        addWriteBack(7, model[6] | model[1]);
        appendWord(rType(FN_XOR, 8, 7, 6, 0));
        addWriteBack(8, model[7] ^ model[6]);
        appendWord(rType(FN_SLT, 9, 8, 7, 0));
        addWriteBack(9, ($signed(model[8]) < $signed(model[7])) ? 32'd1 : 32'd0);
        appendWord(rType(FN_SLL, 10, 0, 8, sh));
        addWriteBack(10, model[8] << sh);
        // stores, then loads of the same words
        appendWord(iType(OP_ADDIU, 0, 12, 16'h0020));
        addWriteBack(12, 32'h20);
        appendWord(iType(OP_SW, 12, 8, 16'h0004));
        addStore(32'h24, model[8]);
        appendWord(iType(OP_SW, 12, 10, 16'h0008));
        addStore(32'h28, model[10]);
        appendWord(iType(OP_LW, 12, 13, 16'h0004));
        addWriteBack(13, model[8]);
        appendWord(iType(OP_LW, 12, 14, 16'h0008));
        addWriteBack(14, model[10]);
        appendWord(iType(OP_ADDIU, 0, 0, immD));   // r0 write, also load spacer
        addWriteBack(0, sext(immD));
        appendWord(rType(FN_ADDU, 16, 13, 14, 0));
        addWriteBack(16, model[13] + model[14]);
        appendWord(rType(FN_ADDU, 17, 0, 1, 0));
        addWriteBack(17, model[1]);
        // jump at word 18, delay slot 19, words 20 and 21 skipped
        appendWord(jType(22));
        appendWord(iType(OP_ADDIU, 0, 18, 16'h0055));
        addWriteBack(18, 32'h55);
        appendSkipped(iType(OP_ADDIU, 0, 19, 16'h0066));
        appendSkipped(iType(OP_ADDIU, 0, 20, 16'h0077));
        appendWord(iType(OP_ADDIU, 18, 18, 16'h0011));
        addWriteBack(18, model[18] + 32'h11);
        // r18 sits in EX/MEM and MEM/WB, newer one wins
        appendWord(rType(FN_ADDU, 22, 18, 17, 0));
        addWriteBack(22, model[18] + model[17]);
        appendWord(iType(OP_ANDI, 22, 23, immE));
        addWriteBack(23, model[22] & {16'h0, immE});
        // self jump keeps fetch parked
        appendWord(jType(25));
        appendWord(NOP_WORD);
    endtask

    // ----------------------------------------
    // write-back and store monitor
    // ----------------------------------------
    always @(negedge clk) begin
        if (!rst && o_writeEnable === 1'b1) begin
            if (wbIdx >= expReg.size()) begin
                errors++;
                $display("%0t ns: unexpected write-back to r%0d", $time, o_writeReg);
            end else begin
                checks += 3;
                assert (o_writeReg === expReg[wbIdx]) else begin
                    errors++;
                    $display("[FAIL] %0t ns: o_writeReg expected %0d, got %0d",
                             $time, expReg[wbIdx], o_writeReg);
                end
                assert (o_writeData === expVal[wbIdx]) else begin
                    errors++;
                    $display("[FAIL] %0t ns: o_writeData expected %h, got %h",
                             $time, expVal[wbIdx], o_writeData);
                end
                assert (cycles === expWbCycle[wbIdx]) else begin
                    errors++;
                    $display("[FAIL] %0t ns: o_writeEnable cycle expected %0d, got %0d",
                             $time, expWbCycle[wbIdx], cycles);
                end
                wbIdx++;
            end
        end
        if (!rst && o_memWrite === 1'b1) begin
            if (stIdx >= expAddr.size()) begin
                errors++;
                $display("%0t ns: unexpected store to address %h", $time, o_dataAddr);
            end else begin
                checks += 3;
                assert (o_dataAddr === expAddr[stIdx]) else begin
                    errors++;
                    $display("[FAIL] %0t ns: o_dataAddr expected %h, got %h",
                             $time, expAddr[stIdx], o_dataAddr);
                end
                assert (o_dataToMem === expData[stIdx]) else begin
                    errors++;
                    $display("[FAIL] %0t ns: o_dataToMem expected %h, got %h",
                             $time, expData[stIdx], o_dataToMem);
                end
                assert (cycles === expStCycle[stIdx]) else begin
                    errors++;
                    $display("[FAIL] %0t ns: o_memWrite cycle expected %0d, got %0d",
                             $time, expStCycle[stIdx], cycles);
                end
                stIdx++;
            end
        end
    end

    initial begin
        i_we              = 1'b0;
        i_halt            = 1'b0;
        i_instructionData = '0;
        errors            = 0;
        checks            = 0;
        wbIdx             = 0;
        stIdx             = 0;
        buildProgram();

        @(posedge clk);
        while (rst) @(posedge clk);

        // load port, one word per cycle
        foreach (prog[i]) begin
            i_we              <= 1'b1;
            i_instructionData <= prog[i];
            @(posedge clk);
        end
        i_we              <= 1'b0;
        i_instructionData <= '0;

        cycles = 0;
        limit  = prog.size() + HALT_LEN + 40;
        while ((wbIdx < expReg.size() || stIdx < expAddr.size()) && cycles < limit) begin
            @(posedge clk);
            cycles++;
            if (cycles == HALT_START) begin
                i_halt <= 1'b1;
            end
            if (cycles == HALT_START + HALT_LEN) begin
                i_halt <= 1'b0;
            end
        end
        i_halt <= 1'b0;

        if (wbIdx < expReg.size() || stIdx < expAddr.size()) begin
            errors++;
            $display("timeout after %0d cycles, %0d write-backs and %0d stores missing",
                     cycles, expReg.size() - wbIdx, expAddr.size() - stIdx);
        end else begin
            repeat (DRAIN) @(posedge clk);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* pipeline.f */
mipsPkg.sv
stageIf.sv
instructionFetch.sv
instructionDecode.sv
forwardingUnit.sv
instructionExecute.sv
memoryWriteBack.sv
pipeline.sv
tbClock.sv
tbPipeline.sv

/* Bender.yml */
package:
  name: pipeline

sources:
  - mipsPkg.sv
  - stageIf.sv
  - instructionFetch.sv
  - instructionDecode.sv
  - forwardingUnit.sv
  - instructionExecute.sv
  - memoryWriteBack.sv
  - pipeline.sv
  - target: test
    files:
      - tbClock.sv
      - tbPipeline.sv
